// ==== rtl/tcm_defs.svh ====
// TCM subsystem configuration
// bus widths, bank depth, address windows, buffer depths and
// the outstanding-counter limit for the data port

`ifndef TCM_DEFS_SVH
`define TCM_DEFS_SVH

// bus widths
`define TCM_ADDR_WIDTH        32
`define TCM_DATA_WIDTH        32

// 16K words per bank
`define TCM_BANK_WORDS_LOG2   14

// address windows, each TCM_BANK_SIZE bytes
`define ITCM_BASE             32'h0000_0000
`define DTCM_BASE             32'h0001_0000
`define TCM_BANK_SIZE         32'h0001_0000

// buffering on the ITCM read path
`define FETCH_RSP_DEPTH       4
`define ITCM_ORDER_DEPTH      4

// data-port counters saturate here
`define OUTSTANDING_MAX       15

`endif

// ==== rtl/tcm_bus_pkg.sv ====
// TCM bus types
// address, data, strobe and bank index types used by the
// requester ports and by the banks

`default_nettype none

`include "tcm_defs.svh"

package tcm_bus_pkg;

    // byte address
    typedef logic [`TCM_ADDR_WIDTH-1:0] addr_t;

    typedef logic [`TCM_DATA_WIDTH-1:0] data_t;

    // one strobe bit per byte lane
    typedef logic [`TCM_DATA_WIDTH/8-1:0] strb_t;

    // word index inside one bank
    typedef logic [`TCM_BANK_WORDS_LOG2-1:0] word_idx_t;

endpackage

`default_nettype wire

// ==== rtl/tcm_map_pkg.sv ====
// TCM memory map
// target and requester encodings, the outstanding counter type
// and the address window decode shared by fetch and data ports

`default_nettype none

`include "tcm_defs.svh"

package tcm_map_pkg;

    import tcm_bus_pkg::*;

    typedef enum logic [1:0] {
        TARGET_ITCM,
        TARGET_DTCM,
        TARGET_NONE
    } tcm_target_t;

    typedef enum logic {
        REQ_FETCH,
        REQ_DATA
    } requester_t;

    typedef logic [$clog2(`OUTSTANDING_MAX + 1)-1:0] outstanding_t;

    // offset compare wraps cleanly, so a zero base needs no special case
    function automatic tcm_target_t decode_target(input addr_t addr);
        if ((addr - `ITCM_BASE) < `TCM_BANK_SIZE) begin
            return TARGET_ITCM;
        end
        if ((addr - `DTCM_BASE) < `TCM_BANK_SIZE) begin
            return TARGET_DTCM;
        end
        return TARGET_NONE;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/tcm_bank.sv ====
// TCM bank
// pseudo-dual-port word memory with independent read and write
// paths. Writes update only the strobed bytes. Read data and the
// write acknowledge are registered and held until taken.

`default_nettype none
`timescale 1ns/100ps

module tcm_bank
    import tcm_bus_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,

    input  wire            rd_valid,
    output logic           rd_ready,
    input  wire word_idx_t rd_idx,

    output logic           rsp_valid,
    input  wire            rsp_ready,
    output data_t          rsp_data,

    input  wire            wr_valid,
    output logic           wr_ready,
    input  wire word_idx_t wr_idx,
    input  wire data_t     wr_data,
    input  wire strb_t     wr_strb,

    output logic           b_valid,
    input  wire            b_ready
);

    localparam int WORDS = 1 << $bits(word_idx_t);

    data_t mem [WORDS];

    // accept when the output slot is free or drains this cycle
    assign rd_ready = !rsp_valid || rsp_ready;
    assign wr_ready = !b_valid || b_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            b_valid   <= 1'b0;
        end else begin
            if (rd_ready) begin
                rsp_valid <= rd_valid;
            end
            if (wr_ready) begin
                b_valid <= wr_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            rsp_data <= mem[rd_idx];
        end
    end

    // byte-lane write
    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
// Synchronous FIFO
// circular buffer with the head entry on pop_data and push and
// pop allowed in the same cycle. The payload is a type parameter.

`default_nettype none
`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          push,
    input  wire payload_t                push_data,
    input  wire                          pop,
    output payload_t                     pop_data,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop_data = slots[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> !push);
    no_underflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        empty |-> !pop);

endmodule

`default_nettype wire

// ==== rtl/itcm_read_arbiter.sv ====
// ITCM read arbiter
// shares the ITCM read path between the fetch port and the data
// port, data port first. Each grant is logged in an order FIFO and
// bank responses are returned by its head. Fetch responses land in
// a credited buffer so a stalled fetch consumer never holds the bank.

`default_nettype none
`timescale 1ns/100ps

`include "tcm_defs.svh"

module itcm_read_arbiter
    import tcm_bus_pkg::*;
    import tcm_map_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,

    input  wire            fetch_ar_valid,
    input  wire addr_t     fetch_ar_addr,
    output logic           fetch_ar_ready,
    output logic           fetch_r_valid,
    output data_t          fetch_r_data,
    input  wire            fetch_r_ready,

    input  wire            dp_ar_valid,
    input  wire addr_t     dp_ar_addr,
    output logic           dp_ar_ready,
    output logic           dp_r_valid,
    output data_t          dp_r_data,
    input  wire            dp_r_ready,

    output logic           itcm_rd_valid,
    input  wire            itcm_rd_ready,
    output word_idx_t      itcm_rd_idx,
    input  wire            itcm_rsp_valid,
    output logic           itcm_rsp_ready,
    input  wire data_t     itcm_rsp_data
);

    localparam int FCNT_W = $clog2(`FETCH_RSP_DEPTH + 1);

    logic              fetch_in_itcm;
    logic              slot_free;
    logic              credit_ok;
    logic              fetch_acc;
    logic              fetch_push;
    logic              fetch_empty;
    logic              fetch_full;
    logic [FCNT_W-1:0] fetch_cnt;
    logic [FCNT_W-1:0] fetch_in_bank;
    logic [FCNT_W:0]   fetch_used;
    logic              order_push;
    logic              order_pop;
    logic              order_empty;
    logic              order_full;
    requester_t        order_head;

    assign fetch_in_itcm = (decode_target(fetch_ar_addr) == TARGET_ITCM);

    // fetch reads still in the bank plus those already buffered
    assign fetch_used = fetch_in_bank + fetch_cnt;
    assign credit_ok  = (fetch_used < `FETCH_RSP_DEPTH);
    assign slot_free  = itcm_rd_ready && !order_full;

    assign dp_ar_ready    = slot_free;
    assign fetch_ar_ready = slot_free && !dp_ar_valid && credit_ok && fetch_in_itcm;
    assign fetch_acc      = fetch_ar_valid && fetch_ar_ready;

    assign itcm_rd_valid = !order_full &&
                           (dp_ar_valid || (fetch_ar_valid && fetch_in_itcm && credit_ok));
    assign itcm_rd_idx   = word_idx_t'((dp_ar_valid ? dp_ar_addr : fetch_ar_addr) >> 2);
    assign order_push    = itcm_rd_valid && itcm_rd_ready;

    // response steering by the oldest grant
    assign itcm_rsp_ready = (order_head == REQ_DATA) ? dp_r_ready : !fetch_full;
    assign order_pop      = itcm_rsp_valid && itcm_rsp_ready;
    assign dp_r_valid     = itcm_rsp_valid && !order_empty && (order_head == REQ_DATA);
    assign dp_r_data      = itcm_rsp_data;
    assign fetch_push     = order_pop && (order_head == REQ_FETCH);
    assign fetch_r_valid  = !fetch_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_in_bank <= '0;
        end else begin
            fetch_in_bank <= fetch_in_bank + FCNT_W'(fetch_acc) - FCNT_W'(fetch_push);
        end
    end

    sync_fifo #(
        .payload_t(requester_t),
        .DEPTH    (`ITCM_ORDER_DEPTH)
    ) order_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (order_push),
        .push_data(dp_ar_valid ? REQ_DATA : REQ_FETCH),
        .pop      (order_pop),
        .pop_data (order_head),
        .empty    (order_empty),
        .full     (order_full),
        .count    ()
    );

    sync_fifo #(
        .payload_t(data_t),
        .DEPTH    (`FETCH_RSP_DEPTH)
    ) fetch_rsp_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (fetch_push),
        .push_data(itcm_rsp_data),
        .pop      (fetch_r_valid && fetch_r_ready),
        .pop_data (fetch_r_data),
        .empty    (fetch_empty),
        .full     (fetch_full),
        .count    (fetch_cnt)
    );

endmodule

`default_nettype wire

// ==== rtl/data_port_router.sv ====
// Data port router
// decodes data-port reads and writes onto the ITCM or DTCM. An
// access waits while the other bank still owes responses of the
// same kind, so read data and write acks return in request order.

`default_nettype none
`timescale 1ns/100ps

`include "tcm_defs.svh"

module data_port_router
    import tcm_bus_pkg::*;
    import tcm_map_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,

    input  wire            data_ar_valid,
    input  wire addr_t     data_ar_addr,
    output logic           data_ar_ready,
    output logic           data_r_valid,
    output data_t          data_r_data,
    input  wire            data_r_ready,
    input  wire            data_wr_valid,
    input  wire addr_t     data_wr_addr,
    input  wire data_t     data_wr_data,
    input  wire strb_t     data_wr_strb,
    output logic           data_wr_ready,
    output logic           data_b_valid,
    input  wire            data_b_ready,

    output logic           itcm_ar_valid,
    output addr_t          itcm_ar_addr,
    input  wire            itcm_ar_ready,
    input  wire            itcm_r_valid,
    input  wire data_t     itcm_r_data,
    output logic           itcm_r_ready,

    output logic           dtcm_rd_valid,
    input  wire            dtcm_rd_ready,
    output word_idx_t      dtcm_rd_idx,
    input  wire            dtcm_rsp_valid,
    output logic           dtcm_rsp_ready,
    input  wire data_t     dtcm_rsp_data,

    output logic           itcm_wr_valid,
    input  wire            itcm_wr_ready,
    output word_idx_t      itcm_wr_idx,
    output data_t          itcm_wr_data,
    output strb_t          itcm_wr_strb,
    input  wire            itcm_b_valid,
    output logic           itcm_b_ready,

    output logic           dtcm_wr_valid,
    input  wire            dtcm_wr_ready,
    output word_idx_t      dtcm_wr_idx,
    output data_t          dtcm_wr_data,
    output strb_t          dtcm_wr_strb,
    input  wire            dtcm_b_valid,
    output logic           dtcm_b_ready
);

    // index 0 is the ITCM, index 1 the DTCM
    outstanding_t rd_cnt [2];
    outstanding_t wr_cnt [2];
    tcm_target_t  rd_tgt;
    tcm_target_t  wr_tgt;
    logic [1:0]   rd_ok;
    logic [1:0]   wr_ok;
    logic [1:0]   rd_sel;
    logic [1:0]   wr_sel;
    logic [1:0]   rd_inc;
    logic [1:0]   rd_dec;
    logic [1:0]   wr_inc;
    logic [1:0]   wr_dec;

    assign rd_tgt = decode_target(data_ar_addr);
    assign wr_tgt = decode_target(data_wr_addr);

    assign rd_sel = {rd_cnt[1] != '0, rd_cnt[0] != '0};
    assign wr_sel = {wr_cnt[1] != '0, wr_cnt[0] != '0};

    // window hit, other bank drained, own counter below the limit
    assign rd_ok[0] = (rd_tgt == TARGET_ITCM) && !rd_sel[1] && (rd_cnt[0] < `OUTSTANDING_MAX);
    assign rd_ok[1] = (rd_tgt == TARGET_DTCM) && !rd_sel[0] && (rd_cnt[1] < `OUTSTANDING_MAX);
    assign wr_ok[0] = (wr_tgt == TARGET_ITCM) && !wr_sel[1] && (wr_cnt[0] < `OUTSTANDING_MAX);
    assign wr_ok[1] = (wr_tgt == TARGET_DTCM) && !wr_sel[0] && (wr_cnt[1] < `OUTSTANDING_MAX);

    assign itcm_ar_valid = data_ar_valid && rd_ok[0];
    assign itcm_ar_addr  = data_ar_addr;
    assign dtcm_rd_valid = data_ar_valid && rd_ok[1];
    assign dtcm_rd_idx   = word_idx_t'(data_ar_addr >> 2);
    assign data_ar_ready = (rd_ok[0] && itcm_ar_ready) || (rd_ok[1] && dtcm_rd_ready);

    assign itcm_wr_valid = data_wr_valid && wr_ok[0];
    assign itcm_wr_idx   = word_idx_t'(data_wr_addr >> 2);
    assign itcm_wr_data  = data_wr_data;
    assign itcm_wr_strb  = data_wr_strb;
    assign dtcm_wr_valid = data_wr_valid && wr_ok[1];
    assign dtcm_wr_idx   = word_idx_t'(data_wr_addr >> 2);
    assign dtcm_wr_data  = data_wr_data;
    assign dtcm_wr_strb  = data_wr_strb;
    assign data_wr_ready = (wr_ok[0] && itcm_wr_ready) || (wr_ok[1] && dtcm_wr_ready);

    // responses come from whichever bank still owes one
    assign data_r_valid   = (rd_sel[0] && itcm_r_valid) || (rd_sel[1] && dtcm_rsp_valid);
    assign data_r_data    = rd_sel[1] ? dtcm_rsp_data : itcm_r_data;
    assign itcm_r_ready   = rd_sel[0] && data_r_ready;
    assign dtcm_rsp_ready = rd_sel[1] && data_r_ready;
    assign data_b_valid   = (wr_sel[0] && itcm_b_valid) || (wr_sel[1] && dtcm_b_valid);
    assign itcm_b_ready   = wr_sel[0] && data_b_ready;
    assign dtcm_b_ready   = wr_sel[1] && data_b_ready;

    assign rd_inc = {dtcm_rd_valid && dtcm_rd_ready, itcm_ar_valid && itcm_ar_ready};
    assign rd_dec = {dtcm_rsp_valid && dtcm_rsp_ready, itcm_r_valid && itcm_r_ready};
    assign wr_inc = {dtcm_wr_valid && dtcm_wr_ready, itcm_wr_valid && itcm_wr_ready};
    assign wr_dec = {dtcm_b_valid && dtcm_b_ready, itcm_b_valid && itcm_b_ready};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2; i++) begin
                rd_cnt[i] <= '0;
                wr_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                rd_cnt[i] <= rd_cnt[i] + outstanding_t'(rd_inc[i]) - outstanding_t'(rd_dec[i]);
                wr_cnt[i] <= wr_cnt[i] + outstanding_t'(wr_inc[i]) - outstanding_t'(wr_dec[i]);
            end
        end
    end

    rd_one_bank_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_sel[0] && rd_sel[1]));
    wr_one_bank_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_sel[0] && wr_sel[1]));

endmodule

`default_nettype wire

// ==== rtl/tcm_subsystem.sv ====
// TCM subsystem top
// instruction and data TCM banks behind a read-only fetch port
// and a read/write data port

`default_nettype none
`timescale 1ns/100ps

module tcm_subsystem
    import tcm_bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,

    input  wire        fetch_ar_valid,
    input  wire addr_t fetch_ar_addr,
    output logic       fetch_ar_ready,
    output logic       fetch_r_valid,
    output data_t      fetch_r_data,
    input  wire        fetch_r_ready,

    input  wire        data_ar_valid,
    input  wire addr_t data_ar_addr,
    output logic       data_ar_ready,
    output logic       data_r_valid,
    output data_t      data_r_data,
    input  wire        data_r_ready,

    input  wire        data_wr_valid,
    input  wire addr_t data_wr_addr,
    input  wire data_t data_wr_data,
    input  wire strb_t data_wr_strb,
    output logic       data_wr_ready,
    output logic       data_b_valid,
    input  wire        data_b_ready
);

    // router to arbiter
    logic      dp_ar_valid;
    addr_t     dp_ar_addr;
    logic      dp_ar_ready;
    logic      dp_r_valid;
    data_t     dp_r_data;
    logic      dp_r_ready;

    // bank read paths
    logic      itcm_rd_valid;
    logic      itcm_rd_ready;
    word_idx_t itcm_rd_idx;
    logic      itcm_rsp_valid;
    logic      itcm_rsp_ready;
    data_t     itcm_rsp_data;
    logic      dtcm_rd_valid;
    logic      dtcm_rd_ready;
    word_idx_t dtcm_rd_idx;
    logic      dtcm_rsp_valid;
    logic      dtcm_rsp_ready;
    data_t     dtcm_rsp_data;

    // bank write paths
    logic      itcm_wr_valid;
    logic      itcm_wr_ready;
    word_idx_t itcm_wr_idx;
    data_t     itcm_wr_data;
    strb_t     itcm_wr_strb;
    logic      itcm_b_valid;
    logic      itcm_b_ready;
    logic      dtcm_wr_valid;
    logic      dtcm_wr_ready;
    word_idx_t dtcm_wr_idx;
    data_t     dtcm_wr_data;
    strb_t     dtcm_wr_strb;
    logic      dtcm_b_valid;
    logic      dtcm_b_ready;

    itcm_read_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_ar_valid(fetch_ar_valid),
        .fetch_ar_addr (fetch_ar_addr),
        .fetch_ar_ready(fetch_ar_ready),
        .fetch_r_valid (fetch_r_valid),
        .fetch_r_data  (fetch_r_data),
        .fetch_r_ready (fetch_r_ready),
        .dp_ar_valid   (dp_ar_valid),
        .dp_ar_addr    (dp_ar_addr),
        .dp_ar_ready   (dp_ar_ready),
        .dp_r_valid    (dp_r_valid),
        .dp_r_data     (dp_r_data),
        .dp_r_ready    (dp_r_ready),
        .itcm_rd_valid (itcm_rd_valid),
        .itcm_rd_ready (itcm_rd_ready),
        .itcm_rd_idx   (itcm_rd_idx),
        .itcm_rsp_valid(itcm_rsp_valid),
        .itcm_rsp_ready(itcm_rsp_ready),
        .itcm_rsp_data (itcm_rsp_data)
    );

    data_port_router u_router (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_ar_valid (data_ar_valid),
        .data_ar_addr  (data_ar_addr),
        .data_ar_ready (data_ar_ready),
        .data_r_valid  (data_r_valid),
        .data_r_data   (data_r_data),
        .data_r_ready  (data_r_ready),
        .data_wr_valid (data_wr_valid),
        .data_wr_addr  (data_wr_addr),
        .data_wr_data  (data_wr_data),
        .data_wr_strb  (data_wr_strb),
        .data_wr_ready (data_wr_ready),
        .data_b_valid  (data_b_valid),
        .data_b_ready  (data_b_ready),
        .itcm_ar_valid (dp_ar_valid),
        .itcm_ar_addr  (dp_ar_addr),
        .itcm_ar_ready (dp_ar_ready),
        .itcm_r_valid  (dp_r_valid),
        .itcm_r_data   (dp_r_data),
        .itcm_r_ready  (dp_r_ready),
        .dtcm_rd_valid (dtcm_rd_valid),
        .dtcm_rd_ready (dtcm_rd_ready),
        .dtcm_rd_idx   (dtcm_rd_idx),
        .dtcm_rsp_valid(dtcm_rsp_valid),
        .dtcm_rsp_ready(dtcm_rsp_ready),
        .dtcm_rsp_data (dtcm_rsp_data),
        .itcm_wr_valid (itcm_wr_valid),
        .itcm_wr_ready (itcm_wr_ready),
        .itcm_wr_idx   (itcm_wr_idx),
        .itcm_wr_data  (itcm_wr_data),
        .itcm_wr_strb  (itcm_wr_strb),
        .itcm_b_valid  (itcm_b_valid),
        .itcm_b_ready  (itcm_b_ready),
        .dtcm_wr_valid (dtcm_wr_valid),
        .dtcm_wr_ready (dtcm_wr_ready),
        .dtcm_wr_idx   (dtcm_wr_idx),
        .dtcm_wr_data  (dtcm_wr_data),
        .dtcm_wr_strb  (dtcm_wr_strb),
        .dtcm_b_valid  (dtcm_b_valid),
        .dtcm_b_ready  (dtcm_b_ready)
    );

    tcm_bank itcm_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_valid (itcm_rd_valid),
        .rd_ready (itcm_rd_ready),
        .rd_idx   (itcm_rd_idx),
        .rsp_valid(itcm_rsp_valid),
        .rsp_ready(itcm_rsp_ready),
        .rsp_data (itcm_rsp_data),
        .wr_valid (itcm_wr_valid),
        .wr_ready (itcm_wr_ready),
        .wr_idx   (itcm_wr_idx),
        .wr_data  (itcm_wr_data),
        .wr_strb  (itcm_wr_strb),
        .b_valid  (itcm_b_valid),
        .b_ready  (itcm_b_ready)
    );

    tcm_bank dtcm_bank (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_valid (dtcm_rd_valid),
        .rd_ready (dtcm_rd_ready),
        .rd_idx   (dtcm_rd_idx),
        .rsp_valid(dtcm_rsp_valid),
        .rsp_ready(dtcm_rsp_ready),
        .rsp_data (dtcm_rsp_data),
        .wr_valid (dtcm_wr_valid),
        .wr_ready (dtcm_wr_ready),
        .wr_idx   (dtcm_wr_idx),
        .wr_data  (dtcm_wr_data),
        .wr_strb  (dtcm_wr_strb),
        .b_valid  (dtcm_b_valid),
        .b_ready  (dtcm_b_ready)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset
// free-running clock and an active-low reset held for a few
// cycles, released shortly after a rising edge

`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(PERIOD / 10);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tcm_subsystem_tb.sv ====
// TCM subsystem testbench
// random strobed writes, fetch reads and data reads checked
// against a byte-level memory model, in request order per port

`default_nettype none
`timescale 1ns/100ps

`include "tcm_defs.svh"

module tcm_subsystem_tb
    import tcm_bus_pkg::*;
    import tcm_map_pkg::*;
();

    localparam int DRIVE_DELAY = 10;
    localparam int N_WORDS     = 12;
    localparam int N_FETCH     = 24;
    localparam int N_CONC      = 16;
    localparam int N_MIXED     = 24;
    // full writes, strobed writes and read-back per bank, then the read tests
    localparam int TOTAL_OPS   = 6 * N_WORDS + N_FETCH + 2 * N_CONC + N_MIXED;

    integer seed = 32'h18e9d19a;

    logic  clk;
    logic  rst_n;
    logic  fetch_ar_valid;
    addr_t fetch_ar_addr;
    logic  fetch_ar_ready;
    logic  fetch_r_valid;
    data_t fetch_r_data;
    logic  fetch_r_ready;
    logic  data_ar_valid;
    addr_t data_ar_addr;
    logic  data_ar_ready;
    logic  data_r_valid;
    data_t data_r_data;
    logic  data_r_ready;
    logic  data_wr_valid;
    addr_t data_wr_addr;
    data_t data_wr_data;
    strb_t data_wr_strb;
    logic  data_wr_ready;
    logic  data_b_valid;
    logic  data_b_ready;

    // byte-accurate reference memory
    logic [7:0] model_mem [addr_t];
    data_t      fetch_exp [$];
    data_t      data_exp [$];
    int         writes_accepted = 0;
    int         b_count = 0;
    addr_t      itcm_words [N_WORDS];
    addr_t      dtcm_words [N_WORDS];

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(3)) clock_gen (.clk(clk), .rst_n(rst_n));

    tcm_subsystem uut (
        .clk(clk), .rst_n(rst_n),
        .fetch_ar_valid(fetch_ar_valid), .fetch_ar_addr(fetch_ar_addr),
        .fetch_ar_ready(fetch_ar_ready), .fetch_r_valid(fetch_r_valid),
        .fetch_r_data(fetch_r_data), .fetch_r_ready(fetch_r_ready),
        .data_ar_valid(data_ar_valid), .data_ar_addr(data_ar_addr),
        .data_ar_ready(data_ar_ready), .data_r_valid(data_r_valid),
        .data_r_data(data_r_data), .data_r_ready(data_r_ready),
        .data_wr_valid(data_wr_valid), .data_wr_addr(data_wr_addr),
        .data_wr_data(data_wr_data), .data_wr_strb(data_wr_strb),
        .data_wr_ready(data_wr_ready), .data_b_valid(data_b_valid),
        .data_b_ready(data_b_ready)
    );

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic data_t model_read(input addr_t addr);
        data_t word;
        for (int b = 0; b < $bits(strb_t); b++) begin
            word[b*8 +: 8] = model_mem[addr + addr_t'(b)];
        end
        return word;
    endfunction

    task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
        for (int b = 0; b < $bits(strb_t); b++) begin
            if (strb[b]) begin
                model_mem[addr + addr_t'(b)] = data[b*8 +: 8];
            end
        end
    endtask

    function automatic addr_t random_word_addr(input addr_t base);
        return base + (addr_t'(word_idx_t'($random(seed))) << 2);
    endfunction

    function automatic int pick_index();
        return int'({$random(seed)} % N_WORDS);
    endfunction

    // each request task starts and ends just after a rising edge
    task automatic fetch_read(input addr_t addr);
        fetch_ar_valid = 1'b1;
        fetch_ar_addr  = addr;
        @(negedge clk);
        while (!fetch_ar_ready) @(negedge clk);
        fetch_exp.push_back(model_read(addr));
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_ar_valid = 1'b0;
    endtask

    task automatic data_read(input addr_t addr);
        data_ar_valid = 1'b1;
        data_ar_addr  = addr;
        @(negedge clk);
        while (!data_ar_ready) @(negedge clk);
        data_exp.push_back(model_read(addr));
        @(posedge clk);
        #DRIVE_DELAY;
        data_ar_valid = 1'b0;
    endtask

    task automatic data_write(input addr_t addr, input data_t data, input strb_t strb);
        data_wr_valid = 1'b1;
        data_wr_addr  = addr;
        data_wr_data  = data;
        data_wr_strb  = strb;
        @(negedge clk);
        while (!data_wr_ready) @(negedge clk);
        model_write(addr, data, strb);
        writes_accepted++;
        @(posedge clk);
        #DRIVE_DELAY;
        data_wr_valid = 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (b_count < writes_accepted || fetch_exp.size() != 0 || data_exp.size() != 0) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
    endtask

    // random back-pressure on every response channel
    always @(posedge clk) begin
        #DRIVE_DELAY;
        fetch_r_ready = ($random(seed) & 3) != 0;
        data_r_ready  = ($random(seed) & 3) != 0;
        data_b_ready  = ($random(seed) & 3) != 0;
    end

    // transfers seen here complete on the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (fetch_r_valid && fetch_r_ready) begin
                if (fetch_exp.size() == 0) begin
                    $display("fetch response arrived with no fetch read outstanding");
                    abort_run();
                end
                check_data("fetch read", fetch_exp.pop_front(), fetch_r_data);
            end
            if (data_r_valid && data_r_ready) begin
                if (data_exp.size() == 0) begin
                    $display("data read response arrived with no data read outstanding");
                    abort_run();
                end
                check_data("data read", data_exp.pop_front(), data_r_data);
            end
            if (data_b_valid && data_b_ready) begin
                b_count++;
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 40) @(posedge clk);
        $display("timeout: no progress after %0d cycles", TOTAL_OPS * 40);
        abort_run();
    end

    initial begin
        fetch_ar_valid = 1'b0;
        fetch_ar_addr  = '0;
        fetch_r_ready  = 1'b0;
        data_ar_valid  = 1'b0;
        data_ar_addr   = '0;
        data_r_ready   = 1'b0;
        data_wr_valid  = 1'b0;
        data_wr_addr   = '0;
        data_wr_data   = '0;
        data_wr_strb   = '0;
        data_b_ready   = 1'b0;
        wait (rst_n);
        @(negedge clk);
        check_count("reset fetch_r_valid", 0, int'(fetch_r_valid));
        check_count("reset data_r_valid", 0, int'(data_r_valid));
        check_count("reset data_b_valid", 0, int'(data_b_valid));
        @(posedge clk);
        #DRIVE_DELAY;

        // full words first so that every byte read later is defined
        for (int i = 0; i < N_WORDS; i++) begin
            itcm_words[i] = random_word_addr(`ITCM_BASE);
            dtcm_words[i] = random_word_addr(`DTCM_BASE);
            data_write(itcm_words[i], data_t'($random(seed)), '1);
            data_write(dtcm_words[i], data_t'($random(seed)), '1);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            data_write(itcm_words[pick_index()], data_t'($random(seed)), strb_t'($random(seed)));
            data_write(dtcm_words[pick_index()], data_t'($random(seed)), strb_t'($random(seed)));
        end
        wait_drained();
        for (int i = 0; i < N_WORDS; i++) begin
            data_read(itcm_words[i]);
            data_read(dtcm_words[i]);
        end
        wait_drained();

        for (int i = 0; i < N_FETCH; i++) begin
            fetch_read(itcm_words[pick_index()]);
        end
        wait_drained();

        // both ports compete for the ITCM
        fork
            begin
                for (int i = 0; i < N_CONC; i++) fetch_read(itcm_words[pick_index()]);
            end
            begin
                for (int i = 0; i < N_CONC; i++) data_read(itcm_words[pick_index()]);
            end
        join
        wait_drained();

        for (int i = 0; i < N_MIXED; i++) begin
            if ($random(seed) & 1) begin
                data_read(itcm_words[pick_index()]);
            end else begin
                data_read(dtcm_words[pick_index()]);
            end
        end
        wait_drained();

        check_count("write responses", writes_accepted, b_count);
        check_count("fetch reads left", 0, fetch_exp.size());
        check_count("data reads left", 0, data_exp.size());
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+rtl
rtl/tcm_bus_pkg.sv
rtl/tcm_map_pkg.sv
rtl/tcm_bank.sv
rtl/sync_fifo.sv
rtl/itcm_read_arbiter.sv
rtl/data_port_router.sv
rtl/tcm_subsystem.sv
verification/tb_clock_gen.sv
verification/tcm_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the TCM subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tcm_subsystem_tb -f project.f -o tcm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tcm_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
